//--- Makefile
TOOL     = verilator
FLAGS    = --binary --assert --timing -Wno-fatal
TOP      = decode_stage_tb
FILELIST = rv64_decode.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Some tests failed
PASS_MSG = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- design/decode_stage.sv
`timescale 1ns/10ps

module decode_stage import rv64_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        instr_push,
    input  instr_t      instr,
    output logic        fifo_full,
    input  logic        stall,
    input  logic        wb_en,
    input  reg_addr_t   wb_addr,
    input  xlen_t       wb_data,
    output decoded_op_t issued_op,
    output logic        out_valid
);

    instr_t      fifo_data_out;
    logic        fifo_empty;
    logic        fifo_pop;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    xlen_t       rs1_regdata;
    xlen_t       rs2_regdata;
    decoded_op_t dec_op;

    instr_fifo u_instr_fifo (
        .clock         (clock),
        .rst_n         (rst_n),
        .instr_push    (instr_push),
        .instr         (instr),
        .fifo_pop      (fifo_pop),
        .fifo_data_out (fifo_data_out),
        .fifo_empty    (fifo_empty),
        .fifo_full     (fifo_full)
    );

    reg_file u_reg_file (
        .clock       (clock),
        .rst_n       (rst_n),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_regdata (rs1_regdata),
        .rs2_regdata (rs2_regdata),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data)
    );

    // Decodes whatever sits at the FIFO head
    decoder u_decoder (
        .fifo_data_out (fifo_data_out),
        .rs1_regdata   (rs1_regdata),
        .rs2_regdata   (rs2_regdata),
        .rs1           (rs1),
        .rs2           (rs2),
        .dec_op        (dec_op)
    );

    issue_reg u_issue_reg (
        .clock      (clock),
        .rst_n      (rst_n),
        .fifo_empty (fifo_empty),
        .stall      (stall),
        .dec_op     (dec_op),
        .fifo_pop   (fifo_pop),
        .issued_op  (issued_op),
        .out_valid  (out_valid)
    );

endmodule

//--- design/decoder.sv
`timescale 1ns/10ps

module decoder import rv64_pkg::*; (
    input  instr_t      fifo_data_out,
    input  xlen_t       rs1_regdata,
    input  xlen_t       rs2_regdata,
    output reg_addr_t   rs1,
    output reg_addr_t   rs2,
    output decoded_op_t dec_op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;

    assign opcode = fifo_data_out[6:0];
    assign funct3 = fifo_data_out[14:12];
    assign funct7 = fifo_data_out[31:25];
    assign rs1    = fifo_data_out[19:15];
    assign rs2    = fifo_data_out[24:20];

    // All immediates sign-extended from bit 31
    assign imm_i = {{52{fifo_data_out[31]}}, fifo_data_out[31:20]};
    assign imm_s = {{52{fifo_data_out[31]}}, fifo_data_out[31:25], fifo_data_out[11:7]};
    assign imm_b = {{51{fifo_data_out[31]}}, fifo_data_out[31], fifo_data_out[7],
                    fifo_data_out[30:25], fifo_data_out[11:8], 1'b0};
    assign imm_u = {{32{fifo_data_out[31]}}, fifo_data_out[31:12], 12'b0};
    assign imm_j = {{43{fifo_data_out[31]}}, fifo_data_out[31], fifo_data_out[19:12],
                    fifo_data_out[20], fifo_data_out[30:21], 1'b0};

    always_comb begin
        dec_op    = '0;
        dec_op.rd = fifo_data_out[11:7];
        case (opcode)
            OPCODE_LUI: begin
                dec_op.imm        = imm_u;
                dec_op.alu_type   = ALU_LUI;
                dec_op.need_to_wb = 1'b1;
            end
            OPCODE_AUIPC: begin
                dec_op.imm        = imm_u;
                dec_op.alu_type   = ALU_AUIPC;
                dec_op.need_to_wb = 1'b1;
            end
            OPCODE_JAL: begin
                dec_op.imm        = imm_j;
                dec_op.cx_type    = CX_JAL;
                dec_op.need_to_wb = 1'b1;
            end
            OPCODE_JALR: begin
                dec_op.imm         = imm_i;
                dec_op.cx_type     = CX_JALR;
                dec_op.need_to_wb  = 1'b1;
                dec_op.src1_is_reg = 1'b1;
            end
            OPCODE_BRANCH: begin
                dec_op.imm         = imm_b;
                dec_op.src1_is_reg = 1'b1;
                dec_op.src2_is_reg = 1'b1;
                case (funct3)
                    3'b000: dec_op.cx_type = CX_BEQ;
                    3'b001: dec_op.cx_type = CX_BNE;
                    3'b100: dec_op.cx_type = CX_BLT;
                    3'b101: dec_op.cx_type = CX_BGE;
                    3'b110: begin
                        dec_op.cx_type     = CX_BLT;
                        dec_op.is_unsigned = 1'b1;
                    end
                    3'b111: begin
                        dec_op.cx_type     = CX_BGE;
                        dec_op.is_unsigned = 1'b1;
                    end
                    default: ;
                endcase
            end
            OPCODE_LOAD: begin
                // funct3[2] marks LBU/LHU/LWU
                dec_op.imm         = imm_i;
                dec_op.is_load     = 1'b1;
                dec_op.need_to_wb  = 1'b1;
                dec_op.src1_is_reg = 1'b1;
                dec_op.ls_size     = funct3[1:0];
                dec_op.is_unsigned = funct3[2];
            end
            OPCODE_STORE: begin
                dec_op.imm         = imm_s;
                dec_op.is_store    = 1'b1;
                dec_op.src1_is_reg = 1'b1;
                dec_op.src2_is_reg = 1'b1;
                dec_op.ls_size     = funct3[1:0];
            end
            OPCODE_ALU_ITYPE: begin
                dec_op.imm         = imm_i;
                dec_op.is_imm      = 1'b1;
                dec_op.need_to_wb  = 1'b1;
                dec_op.src1_is_reg = 1'b1;
                case (funct3)
                    3'b000: dec_op.alu_type = ALU_ADD;
                    3'b010: dec_op.alu_type = ALU_SLT;
                    3'b011: begin
                        dec_op.alu_type    = ALU_SLT;
                        dec_op.is_unsigned = 1'b1;
                    end
                    3'b100: dec_op.alu_type = ALU_XOR;
                    3'b110: dec_op.alu_type = ALU_OR;
                    3'b111: dec_op.alu_type = ALU_AND;
                    // 6-bit shamt, so only funct7[6:1] selects
                    3'b001: begin
                        if (funct7[6:1] == 6'b000000) dec_op.alu_type = ALU_SLL;
                    end
                    3'b101: begin
                        if (funct7[6:1] == 6'b000000) begin
                            dec_op.alu_type = ALU_SRL;
                        end else if (funct7[6:1] == 6'b010000) begin
                            dec_op.alu_type = ALU_SRA;
                        end
                    end
                    default: ;
                endcase
            end
            OPCODE_ALU_RTYPE: begin
                dec_op.need_to_wb  = 1'b1;
                dec_op.src1_is_reg = 1'b1;
                dec_op.src2_is_reg = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: dec_op.alu_type = ALU_ADD;
                    10'b0100000_000: dec_op.alu_type = ALU_SUB;
                    10'b0000000_001: dec_op.alu_type = ALU_SLL;
                    10'b0000000_010: dec_op.alu_type = ALU_SLT;
                    10'b0000000_011: begin
                        dec_op.alu_type    = ALU_SLT;
                        dec_op.is_unsigned = 1'b1;
                    end
                    10'b0000000_100: dec_op.alu_type = ALU_XOR;
                    10'b0000000_101: dec_op.alu_type = ALU_SRL;
                    10'b0100000_101: dec_op.alu_type = ALU_SRA;
                    10'b0000000_110: dec_op.alu_type = ALU_OR;
                    10'b0000000_111: dec_op.alu_type = ALU_AND;
                    default: ;
                endcase
            end
            OPCODE_ALU_ITYPE_WORD: begin
                dec_op.imm         = imm_i;
                dec_op.is_imm      = 1'b1;
                dec_op.is_word     = 1'b1;
                dec_op.need_to_wb  = 1'b1;
                dec_op.src1_is_reg = 1'b1;
                case ({funct7, funct3}) inside
                    10'b???????_000: dec_op.alu_type = ALU_ADD;
                    10'b0000000_001: dec_op.alu_type = ALU_SLL;
                    10'b0000000_101: dec_op.alu_type = ALU_SRL;
                    10'b0100000_101: dec_op.alu_type = ALU_SRA;
                    default: ;
                endcase
            end
            OPCODE_ALU_RTYPE_WORD: begin
                dec_op.is_word     = 1'b1;
                dec_op.need_to_wb  = 1'b1;
                dec_op.src1_is_reg = 1'b1;
                dec_op.src2_is_reg = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: dec_op.alu_type = ALU_ADD;
                    10'b0100000_000: dec_op.alu_type = ALU_SUB;
                    10'b0000000_001: dec_op.alu_type = ALU_SLL;
                    10'b0000000_101: dec_op.alu_type = ALU_SRL;
                    10'b0100000_101: dec_op.alu_type = ALU_SRA;
                    default: ;
                endcase
            end
            OPCODE_FENCE, OPCODE_ENV: ;  // Nothing to execute here
            default: ;
        endcase

        dec_op.src1 = dec_op.src1_is_reg ? rs1_regdata : '0;
        dec_op.src2 = dec_op.src2_is_reg ? rs2_regdata : '0;
    end

endmodule

//--- design/instr_fifo.sv
`timescale 1ns/10ps

module instr_fifo import rv64_pkg::*; (
    input  logic   clock,
    input  logic   rst_n,
    input  logic   instr_push,
    input  instr_t instr,
    input  logic   fifo_pop,
    output instr_t fifo_data_out,
    output logic   fifo_empty,
    output logic   fifo_full
);

    instr_t    mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0] count;
    logic      do_push;
    logic      do_pop;

    assign fifo_empty = (count == '0);
    assign fifo_full  = (count == FIFO_DEPTH);
    assign do_push    = instr_push && !fifo_full;  // Dropped when full
    assign do_pop     = fifo_pop && !fifo_empty;

    assign fifo_data_out = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= instr;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == fifo_ptr_t'(FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == fifo_ptr_t'(FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- design/issue_reg.sv
`timescale 1ns/10ps

module issue_reg import rv64_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        fifo_empty,
    input  logic        stall,
    input  decoded_op_t dec_op,
    output logic        fifo_pop,
    output decoded_op_t issued_op,
    output logic        out_valid
);

    logic hold;

    // Execute not ready for a new op
    assign hold     = out_valid && stall;
    assign fifo_pop = !fifo_empty && !hold;

    always_ff @(posedge clock) begin
        if (fifo_pop) begin
            issued_op <= dec_op;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (fifo_pop) begin
            out_valid <= 1'b1;
        end else if (!hold) begin
            out_valid <= 1'b0;  // Drained
        end
    end

endmodule

//--- design/reg_file.sv
`timescale 1ns/10ps

module reg_file import rv64_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output xlen_t     rs1_regdata,
    output xlen_t     rs2_regdata,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  xlen_t     wb_data
);

    xlen_t regs [1:31];  // x0 has no storage

    // Old value on a same-cycle write
    assign rs1_regdata = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_regdata = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

endmodule

//--- design/rv64_pkg.sv
package rv64_pkg;

    localparam int FIFO_DEPTH = 4;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  cx_op_t;
    typedef logic [1:0]  ls_size_t;
    typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;

    // Major opcodes, instr[6:0]
    localparam logic [6:0] OPCODE_LUI            = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC          = 7'b0010111;
    localparam logic [6:0] OPCODE_JAL            = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR           = 7'b1100111;
    localparam logic [6:0] OPCODE_BRANCH         = 7'b1100011;
    localparam logic [6:0] OPCODE_LOAD           = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE          = 7'b0100011;
    localparam logic [6:0] OPCODE_ALU_ITYPE      = 7'b0010011;
    localparam logic [6:0] OPCODE_ALU_RTYPE      = 7'b0110011;
    localparam logic [6:0] OPCODE_FENCE          = 7'b0001111;
    localparam logic [6:0] OPCODE_ENV            = 7'b1110011;
    localparam logic [6:0] OPCODE_ALU_ITYPE_WORD = 7'b0011011;
    localparam logic [6:0] OPCODE_ALU_RTYPE_WORD = 7'b0111011;

    localparam alu_op_t ALU_NONE  = 4'd0;
    localparam alu_op_t ALU_ADD   = 4'd1;
    localparam alu_op_t ALU_SUB   = 4'd2;
    localparam alu_op_t ALU_SLL   = 4'd3;
    localparam alu_op_t ALU_SLT   = 4'd4;  // SLTU via is_unsigned
    localparam alu_op_t ALU_XOR   = 4'd5;
    localparam alu_op_t ALU_SRL   = 4'd6;
    localparam alu_op_t ALU_SRA   = 4'd7;
    localparam alu_op_t ALU_OR    = 4'd8;
    localparam alu_op_t ALU_AND   = 4'd9;
    localparam alu_op_t ALU_LUI   = 4'd10;
    localparam alu_op_t ALU_AUIPC = 4'd11;

    // Unsigned branches reuse BLT/BGE with is_unsigned
    localparam cx_op_t CX_NONE = 3'd0;
    localparam cx_op_t CX_JAL  = 3'd1;
    localparam cx_op_t CX_JALR = 3'd2;
    localparam cx_op_t CX_BEQ  = 3'd3;
    localparam cx_op_t CX_BNE  = 3'd4;
    localparam cx_op_t CX_BLT  = 3'd5;
    localparam cx_op_t CX_BGE  = 3'd6;

    localparam ls_size_t LS_B = 2'd0;
    localparam ls_size_t LS_H = 2'd1;
    localparam ls_size_t LS_W = 2'd2;
    localparam ls_size_t LS_D = 2'd3;

    typedef struct packed {
        reg_addr_t rd;
        xlen_t     src1;
        xlen_t     src2;
        xlen_t     imm;
        logic      src1_is_reg;
        logic      src2_is_reg;
        logic      need_to_wb;
        cx_op_t    cx_type;
        logic      is_unsigned;
        alu_op_t   alu_type;
        logic      is_word;
        logic      is_imm;
        logic      is_load;
        logic      is_store;
        ls_size_t  ls_size;
    } decoded_op_t;

endpackage

//--- rv64_decode.f
design/rv64_pkg.sv
design/instr_fifo.sv
design/reg_file.sv
design/decoder.sv
design/issue_reg.sv
design/decode_stage.sv
verif/decode_stage_properties.sv
verif/decode_stage_tb.sv

//--- verif/decode_stage_properties.sv
`timescale 1ns/10ps

module decode_stage_properties import rv64_pkg::*; (
    input logic        clock,
    input logic        rst_n,
    input logic        fifo_pop,
    input logic        fifo_empty,
    input logic        fifo_full,
    input logic        stall,
    input logic        out_valid,
    input decoded_op_t issued_op
);

    a_no_pop_when_empty: assert property (@(posedge clock) disable iff (!rst_n)
        !(fifo_pop && fifo_empty))
        else $error("fifo_pop high while FIFO is empty");

    // Holding means valid output with execute stalled
    a_hold_stable: assert property (@(posedge clock) disable iff (!rst_n)
        (out_valid && stall) |=> (out_valid && $stable(issued_op)))
        else $error("issued_op or out_valid changed while holding");

    a_full_not_empty: assert property (@(posedge clock) disable iff (!rst_n)
        !(fifo_full && fifo_empty))
        else $error("fifo_full and fifo_empty both high");

    a_valid_low_after_reset: assert property (@(posedge clock)
        $rose(rst_n) |-> !out_valid)
        else $error("out_valid high right after reset release");

endmodule

bind decode_stage decode_stage_properties u_properties (
    .clock      (clock),
    .rst_n      (rst_n),
    .fifo_pop   (fifo_pop),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full),
    .stall      (stall),
    .out_valid  (out_valid),
    .issued_op  (issued_op)
);

//--- verif/decode_stage_tb.sv
`timescale 1ns/10ps

module decode_stage_tb import rv64_pkg::*; ();

    localparam int    TIMEOUT = 50;
    localparam xlen_t R1_VAL  = 64'h0123_4567_89ab_cdef;
    localparam xlen_t R2_VAL  = 64'hfedc_ba98_7654_3210;
    localparam xlen_t R3_VAL  = 64'h0000_0000_dead_beef;
    localparam xlen_t NEG_1   = 64'hffff_ffff_ffff_ffff;

    typedef struct {
        string       name;
        instr_t      word;
        decoded_op_t exp;
    } test_case_t;

    logic        clock;
    logic        rst_n;
    logic        instr_push;
    instr_t      instr;
    logic        fifo_full;
    logic        stall;
    logic        wb_en;
    reg_addr_t   wb_addr;
    xlen_t       wb_data;
    decoded_op_t issued_op;
    logic        out_valid;
    test_case_t  cases[$];

    decode_stage DUT (
        .clock      (clock),
        .rst_n      (rst_n),
        .instr_push (instr_push),
        .instr      (instr),
        .fifo_full  (fifo_full),
        .stall      (stall),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .issued_op  (issued_op),
        .out_valid  (out_valid)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_field(input string test, input string field,
                               input xlen_t exp, input xlen_t act);
        assert (act === exp) else begin
            $display("ERR %s %s expected %h actual %h", test, field, exp, act);
            stop_run();
        end
    endtask

    task automatic compare_issued(input string test, input decoded_op_t exp);
        decoded_op_t act;
        act = issued_op;
        check_field(test, "rd", xlen_t'(exp.rd), xlen_t'(act.rd));
        check_field(test, "src1", exp.src1, act.src1);
        check_field(test, "src2", exp.src2, act.src2);
        check_field(test, "imm", exp.imm, act.imm);
        check_field(test, "src1_is_reg", xlen_t'(exp.src1_is_reg), xlen_t'(act.src1_is_reg));
        check_field(test, "src2_is_reg", xlen_t'(exp.src2_is_reg), xlen_t'(act.src2_is_reg));
        check_field(test, "need_to_wb", xlen_t'(exp.need_to_wb), xlen_t'(act.need_to_wb));
        check_field(test, "cx_type", xlen_t'(exp.cx_type), xlen_t'(act.cx_type));
        check_field(test, "is_unsigned", xlen_t'(exp.is_unsigned), xlen_t'(act.is_unsigned));
        check_field(test, "alu_type", xlen_t'(exp.alu_type), xlen_t'(act.alu_type));
        check_field(test, "is_word", xlen_t'(exp.is_word), xlen_t'(act.is_word));
        check_field(test, "is_imm", xlen_t'(exp.is_imm), xlen_t'(act.is_imm));
        check_field(test, "is_load", xlen_t'(exp.is_load), xlen_t'(act.is_load));
        check_field(test, "is_store", xlen_t'(exp.is_store), xlen_t'(act.is_store));
        check_field(test, "ls_size", xlen_t'(exp.ls_size), xlen_t'(act.ls_size));
    endtask

    task automatic wait_valid(input string test, output int cycles);
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!out_valid && cycles < TIMEOUT);
        assert (out_valid) else begin
            $display("Timeout in %s: out_valid never went high", test);
            stop_run();
        end
    endtask

    task automatic wait_full(input string test);
        int cycles;
        cycles = 0;
        while (!fifo_full && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        assert (fifo_full) else begin
            $display("Timeout in %s: fifo_full never went high", test);
            stop_run();
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input xlen_t data);
        @(negedge clock);
        wb_en   = 1'b1;
        wb_addr = addr;
        wb_data = data;
    endtask

    task automatic push_word(input instr_t word);
        @(negedge clock);
        instr_push = 1'b1;
        instr      = word;
        @(negedge clock);
        instr_push = 1'b0;
    endtask

    task automatic add_case(input string name, input instr_t word, input decoded_op_t exp);
        test_case_t tc;
        tc.name = name;
        tc.word = word;
        tc.exp  = exp;
        cases.push_back(tc);
    endtask

    // ADDI x1, x0, k
    function automatic instr_t addi_word(input int k);
        return {12'(k), 20'h00093};
    endfunction

    // Expected bundles worked out by hand from the encodings
    task automatic load_cases();
        add_case("lui_neg", 32'h800080b7, decoded_op_t'{rd: 5'd1,
            imm: 64'hffff_ffff_8000_8000, need_to_wb: 1'b1, alu_type: ALU_LUI, default: '0});
        add_case("auipc_pos", 32'h12345297, decoded_op_t'{rd: 5'd5,
            imm: 64'h1234_5000, need_to_wb: 1'b1, alu_type: ALU_AUIPC, default: '0});
        add_case("jal_neg", 32'hffdff0ef, decoded_op_t'{rd: 5'd1, imm: -64'sd4,
            need_to_wb: 1'b1, cx_type: CX_JAL, default: '0});
        add_case("jalr_pos", 32'h01008067, decoded_op_t'{imm: 64'd16, src1: R1_VAL,
            src1_is_reg: 1'b1, need_to_wb: 1'b1, cx_type: CX_JALR, default: '0});
        add_case("beq_neg", 32'hfe208ce3, decoded_op_t'{rd: 5'd25, imm: -64'sd8,
            src1: R1_VAL, src2: R2_VAL, src1_is_reg: 1'b1, src2_is_reg: 1'b1,
            cx_type: CX_BEQ, default: '0});
        add_case("bltu_neg", 32'hfe20ece3, decoded_op_t'{rd: 5'd25, imm: -64'sd8,
            src1: R1_VAL, src2: R2_VAL, src1_is_reg: 1'b1, src2_is_reg: 1'b1,
            cx_type: CX_BLT, is_unsigned: 1'b1, default: '0});
        add_case("bgeu_pos", 32'h1001f063, decoded_op_t'{imm: 64'd256, src1: R3_VAL,
            src1_is_reg: 1'b1, src2_is_reg: 1'b1, cx_type: CX_BGE, is_unsigned: 1'b1,
            default: '0});
        add_case("sd_neg", 32'hfe20b823, decoded_op_t'{rd: 5'd16, imm: -64'sd16,
            src1: R1_VAL, src2: R2_VAL, src1_is_reg: 1'b1, src2_is_reg: 1'b1,
            is_store: 1'b1, ls_size: LS_D, default: '0});
        add_case("sb_x0_base", 32'h003002a3, decoded_op_t'{rd: 5'd5, imm: 64'd5,
            src2: R3_VAL, src1_is_reg: 1'b1, src2_is_reg: 1'b1, is_store: 1'b1,
            ls_size: LS_B, default: '0});
        add_case("lw", 32'h00812203, decoded_op_t'{rd: 5'd4, imm: 64'd8, src1: R2_VAL,
            src1_is_reg: 1'b1, need_to_wb: 1'b1, is_load: 1'b1, ls_size: LS_W, default: '0});
        add_case("lwu_neg", 32'hfff0e203, decoded_op_t'{rd: 5'd4, imm: NEG_1, src1: R1_VAL,
            src1_is_reg: 1'b1, need_to_wb: 1'b1, is_load: 1'b1, ls_size: LS_W,
            is_unsigned: 1'b1, default: '0});
        add_case("lbu", 32'h0001c303, decoded_op_t'{rd: 5'd6, src1: R3_VAL,
            src1_is_reg: 1'b1, need_to_wb: 1'b1, is_load: 1'b1, ls_size: LS_B,
            is_unsigned: 1'b1, default: '0});
        add_case("addi_neg", 32'hfff08393, decoded_op_t'{rd: 5'd7, imm: NEG_1, src1: R1_VAL,
            src1_is_reg: 1'b1, need_to_wb: 1'b1, alu_type: ALU_ADD, is_imm: 1'b1, default: '0});
        add_case("sltiu", 32'h00113413, decoded_op_t'{rd: 5'd8, imm: 64'd1, src1: R2_VAL,
            src1_is_reg: 1'b1, need_to_wb: 1'b1, alu_type: ALU_SLT, is_unsigned: 1'b1,
            is_imm: 1'b1, default: '0});
        add_case("srai", 32'h43f0d493, decoded_op_t'{rd: 5'd9, imm: 64'h43f, src1: R1_VAL,
            src1_is_reg: 1'b1, need_to_wb: 1'b1, alu_type: ALU_SRA, is_imm: 1'b1, default: '0});
        add_case("add", 32'h00208533, decoded_op_t'{rd: 5'd10, src1: R1_VAL, src2: R2_VAL,
            src1_is_reg: 1'b1, src2_is_reg: 1'b1, need_to_wb: 1'b1, alu_type: ALU_ADD,
            default: '0});
        add_case("sub", 32'h40208533, decoded_op_t'{rd: 5'd10, src1: R1_VAL, src2: R2_VAL,
            src1_is_reg: 1'b1, src2_is_reg: 1'b1, need_to_wb: 1'b1, alu_type: ALU_SUB,
            default: '0});
        add_case("srl", 32'h0011d5b3, decoded_op_t'{rd: 5'd11, src1: R3_VAL, src2: R1_VAL,
            src1_is_reg: 1'b1, src2_is_reg: 1'b1, need_to_wb: 1'b1, alu_type: ALU_SRL,
            default: '0});
        add_case("sra", 32'h4011d5b3, decoded_op_t'{rd: 5'd11, src1: R3_VAL, src2: R1_VAL,
            src1_is_reg: 1'b1, src2_is_reg: 1'b1, need_to_wb: 1'b1, alu_type: ALU_SRA,
            default: '0});
        add_case("sltu_x0", 32'h00203633, decoded_op_t'{rd: 5'd12, src2: R2_VAL,
            src1_is_reg: 1'b1, src2_is_reg: 1'b1, need_to_wb: 1'b1, alu_type: ALU_SLT,
            is_unsigned: 1'b1, default: '0});
        add_case("addiw", 32'h0640869b, decoded_op_t'{rd: 5'd13, imm: 64'd100,
            src1: R1_VAL, src1_is_reg: 1'b1, need_to_wb: 1'b1, alu_type: ALU_ADD,
            is_imm: 1'b1, is_word: 1'b1, default: '0});
        add_case("subw", 32'h4031073b, decoded_op_t'{rd: 5'd14, src1: R2_VAL, src2: R3_VAL,
            src1_is_reg: 1'b1, src2_is_reg: 1'b1, need_to_wb: 1'b1, alu_type: ALU_SUB,
            is_word: 1'b1, default: '0});
        add_case("fence", 32'h0ff0000f, decoded_op_t'{default: '0});
        add_case("ecall", 32'h00000073, decoded_op_t'{default: '0});
        add_case("unknown_op", 32'h0000007f, decoded_op_t'{default: '0});
    endtask

    initial begin
        int          cycles;
        decoded_op_t held;
        rst_n      = 1'b0;
        instr_push = 1'b0;
        instr      = '0;
        stall      = 1'b0;
        wb_en      = 1'b0;
        wb_addr    = '0;
        wb_data    = '0;
        repeat (10) @(negedge clock);
        rst_n = 1'b1;

        write_reg(5'd1, R1_VAL);
        write_reg(5'd2, R2_VAL);
        write_reg(5'd3, R3_VAL);
        write_reg(5'd0, 64'hbad0_bad0_bad0_bad0);  // x0 stays zero
        @(negedge clock);
        wb_en = 1'b0;

        load_cases();
        foreach (cases[i]) begin
            push_word(cases[i].word);
            wait_valid(cases[i].name, cycles);
            check_field(cases[i].name, "latency", 64'd1, xlen_t'(cycles));
            compare_issued(cases[i].name, cases[i].exp);
        end

        // Hold the last op and fill the FIFO behind it, one push too many
        stall = 1'b1;
        held  = cases[cases.size()-1].exp;
        for (int k = 1; k <= FIFO_DEPTH + 1; k++) begin
            @(negedge clock);
            instr_push = 1'b1;
            instr      = addi_word(k);
        end
        @(negedge clock);
        instr_push = 1'b0;
        wait_full("stall_fill");
        compare_issued("stall_hold", held);
        check_field("stall_hold", "out_valid", 64'd1, xlen_t'(out_valid));

        stall = 1'b0;
        for (int k = 1; k <= FIFO_DEPTH; k++) begin
            wait_valid("drain", cycles);
            check_field("drain", "imm", xlen_t'(k), issued_op.imm);  // Push order
        end
        @(negedge clock);
        check_field("drain", "extra_valid", 64'd0, xlen_t'(out_valid));

        $display("All tests passed");
        $finish;
    end

endmodule
